// ==== Makefile ====
SIM := obj_dir/Vspi_bridge_tb

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard verilog/*.sv) $(wildcard dv/*.sv)
	verilator --binary --assert -Wno-fatal -f build.f --top-module spi_bridge_tb \
		-o Vspi_bridge_tb

run: $(SIM)
	out="$$(./$(SIM) +verilator+error+limit+1000 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// ==== build.f ====
verilog/spi_link_pkg.sv
verilog/axil_to_axis.sv
verilog/spi_byte_master.sv
verilog/spi_byte_target.sv
verilog/axis_to_regs.sv
verilog/spi_bridge_top.sv
dv/spi_bridge_assertions.sv
dv/spi_bridge_tb.sv

// ==== dv/spi_bridge_assertions.sv ====
`default_nettype none

module spi_bridge_assertions (
  input wire                                      clock,
  input wire                                      reset,
  input wire                                      awready_i,
  input wire                                      arready_i,
  input wire                                      bvalid_i,
  input wire                                      bready_i,
  input wire [1:0]                                bresp_i,
  input wire                                      rvalid_i,
  input wire                                      rready_i,
  input wire [spi_link_pkg::axil_data_bits_c-1:0] rdata_i,
  input wire [1:0]                                rresp_i,
  input wire                                      tx_valid_i,
  input wire                                      tx_ready_i,
  input wire                                      tx_last_i,
  input wire [7:0]                                tx_data_i,
  input wire [7:0]                                hdr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  import spi_link_pkg::*;

  int b_hold_fails = 0;
  int r_hold_fails = 0;
  int accept_fails = 0;
  int frame_fails = 0;
  int fail_count;
  logic frame_start_q;

  assign fail_count = b_hold_fails + r_hold_fails + accept_fails + frame_fails;

  // Next byte on the stream opens a frame
  always_ff @(posedge clock) begin
    if (reset) begin
      frame_start_q <= 1'b1;
    end else if (tx_valid_i && tx_ready_i) begin
      frame_start_q <= tx_last_i;
    end
  end

  b_held: assert property (@(posedge clock) disable iff (reset)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("write response changed before its handshake");
      b_hold_fails++;
    end

  r_held: assert property (@(posedge clock) disable iff (reset)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("read response changed before its handshake");
      r_hold_fails++;
    end

  no_accept_pending: assert property (@(posedge clock) disable iff (reset)
      bvalid_i || rvalid_i |-> !awready_i && !arready_i)
    else begin
      $error("address accepted while a response is pending");
      accept_fails++;
    end

  // A frame starts with a request header or a poll byte
  frame_open: assert property (@(posedge clock) disable iff (reset)
      tx_valid_i && tx_ready_i && frame_start_q |-> tx_data_i == fill_byte_c ||
                                                    tx_data_i == hdr_i)
    else begin
      $error("frame opened with a byte that is neither header nor fill");
      frame_fails++;
    end

endmodule

bind axil_to_axis spi_bridge_assertions i_assertions (
  .clock      (clock),
  .reset      (reset),
  .awready_i  (awready_o),
  .arready_i  (arready_o),
  .bvalid_i   (bvalid_o),
  .bready_i   (bready_i),
  .bresp_i    (bresp_o),
  .rvalid_i   (rvalid_o),
  .rready_i   (rready_i),
  .rdata_i    (rdata_o),
  .rresp_i    (rresp_o),
  .tx_valid_i (tx_valid_o),
  .tx_ready_i (tx_ready_i),
  .tx_last_i  (tx_last_o),
  .tx_data_i  (tx_data_o),
  .hdr_i      (hdr_q)
);

`default_nettype wire

// ==== dv/spi_bridge_tb.sv ====
`default_nettype none

module spi_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import spi_link_pkg::*;

  // About 60 transactions of up to 400 cycles each, with a margin of two
  localparam int timeout_cycles_c = 50000;

  logic clock;
  logic reset;
  logic awvalid;
  logic awready;
  logic [axil_addr_bits_c-1:0] awaddr;
  logic wvalid;
  logic wready;
  logic [axil_data_bits_c-1:0] wdata;
  logic [axil_data_bits_c/8-1:0] wstrb;
  logic bvalid;
  logic bready;
  logic [1:0] bresp;
  logic arvalid;
  logic arready;
  logic [axil_addr_bits_c-1:0] araddr;
  logic rvalid;
  logic rready;
  logic [axil_data_bits_c-1:0] rdata;
  logic [1:0] rresp;

  logic [axil_data_bits_c-1:0] model [reg_count_c];
  logic [15:0] lfsr_q = 16'd42711;
  int cycle_count = 0;

  spi_bridge_top i_dut (
    .clock     (clock),
    .reset     (reset),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  always #2 clock = ~clock;

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles_c) begin
      stop_with_failure($sformatf("run stopped, no result after %0d clock cycles",
                                  timeout_cycles_c));
    end else if (i_dut.i_axil_to_axis.i_assertions.fail_count != 0) begin
      stop_with_failure($sformatf("%0d bound assertion checks did not hold",
                                  i_dut.i_axil_to_axis.i_assertions.fail_count));
    end
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [reg_index_bits_c-1:0] random_index();
    return reg_index_bits_c'(random_bits(4) % 15);
  endfunction

  // Byte lanes with their strobe set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic [31:0] expected_word(input logic [reg_index_bits_c-1:0] index);
    return (index == id_reg_index_c) ? id_reg_value_c : model[index];
  endfunction

  task automatic check_data(input string what, input logic [axil_data_bits_c-1:0] got,
                            input logic [axil_data_bits_c-1:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                  $time, what, got, expected));
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] got,
                            input logic [1:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                                  $time, what, got, expected));
    end
  endtask

  task automatic wait_write_accept();
    do begin
      @(posedge clock);
      if (arready) begin
        stop_with_failure("read address accepted while a write was waiting");
      end
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid <= 1'b0;
  endtask

  task automatic wait_write_response(input int delay, output logic [1:0] resp);
    do begin
      @(posedge clock);
      if (arready) begin
        stop_with_failure("read address accepted before the write response");
      end
    end while (!bvalid);
    resp = bresp;
    repeat (delay) begin
      @(posedge clock);
      if (!bvalid) begin
        stop_with_failure("write response withdrawn before bready");
      end
      check_resp("held bresp", bresp, resp);
    end
    bready <= 1'b1;
    @(posedge clock);
    bready <= 1'b0;
  endtask

  task automatic wait_read_accept();
    do @(posedge clock); while (!arready);
    arvalid <= 1'b0;
  endtask

  task automatic wait_read_response(input int delay, output logic [31:0] word,
                                    output logic [1:0] resp);
    do @(posedge clock); while (!rvalid);
    word = rdata;
    resp = rresp;
    repeat (delay) begin
      @(posedge clock);
      if (!rvalid) begin
        stop_with_failure("read response withdrawn before rready");
      end
      check_data("held rdata", rdata, word);
      check_resp("held rresp", rresp, resp);
    end
    rready <= 1'b1;
    @(posedge clock);
    rready <= 1'b0;
  endtask

  task automatic axil_write(input logic [reg_index_bits_c-1:0] index,
                            input logic [31:0] data, input logic [3:0] strb,
                            input int delay, output logic [1:0] resp);
    awvalid <= 1'b1;
    awaddr <= {index, 2'b00};
    wvalid <= 1'b1;
    wdata <= data;
    wstrb <= strb;
    wait_write_accept();
    wait_write_response(delay, resp);
  endtask

  task automatic axil_read(input logic [reg_index_bits_c-1:0] index, input int delay,
                           output logic [31:0] word, output logic [1:0] resp);
    arvalid <= 1'b1;
    araddr <= {index, 2'b00};
    wait_read_accept();
    wait_read_response(delay, word, resp);
  endtask

  task automatic write_then_read(input logic [reg_index_bits_c-1:0] index,
                                 input logic [31:0] data, input logic [3:0] strb,
                                 input int write_delay, input int read_delay);
    logic [31:0] word;
    logic [1:0] resp;
    axil_write(index, data, strb, write_delay, resp);
    check_resp($sformatf("bresp of reg %0d", index), resp,
               (index == id_reg_index_c) ? resp_slverr_c : resp_okay_c);
    // The ID register refuses writes
    if (index != id_reg_index_c) begin
      model[index] = merge_bytes(model[index], data, strb);
    end
    axil_read(index, read_delay, word, resp);
    check_resp($sformatf("rresp of reg %0d", index), resp, resp_okay_c);
    check_data($sformatf("rdata of reg %0d", index), word, expected_word(index));
  endtask

  task automatic reset_values_read();
    logic [31:0] word;
    logic [1:0] resp;
    for (int i = 0; i < reg_count_c; i++) begin
      axil_read(reg_index_bits_c'(i), 0, word, resp);
      check_resp($sformatf("rresp of reg %0d after reset", i), resp, resp_okay_c);
      check_data($sformatf("reg %0d after reset", i), word,
                 expected_word(reg_index_bits_c'(i)));
    end
  endtask

  task automatic full_word_writes();
    repeat (10) begin
      write_then_read(random_index(), random_bits(32), 4'hF, 0, 0);
    end
  endtask

  task automatic partial_strobe_writes();
    repeat (6) begin
      write_then_read(random_index(), random_bits(32), 4'(random_bits(4)), 0, 0);
    end
  endtask

  task automatic id_register_write();
    write_then_read(reg_index_bits_c'(id_reg_index_c), random_bits(32), 4'hF, 0, 0);
  endtask

  task automatic response_backpressure();
    repeat (4) begin
      write_then_read(random_index(), random_bits(32), 4'hF,
                      int'(random_bits(5)), int'(random_bits(5)));
    end
  endtask

  // Write wins, so the read sees the new value
  task automatic simultaneous_write_read();
    logic [reg_index_bits_c-1:0] index;
    logic [31:0] data;
    logic [31:0] word;
    logic [1:0] resp;
    index = random_index();
    data = random_bits(32);
    awvalid <= 1'b1;
    awaddr <= {index, 2'b00};
    wvalid <= 1'b1;
    wdata <= data;
    wstrb <= 4'hF;
    arvalid <= 1'b1;
    araddr <= {index, 2'b00};
    wait_write_accept();
    wait_write_response(0, resp);
    check_resp("bresp of simultaneous write", resp, resp_okay_c);
    model[index] = data;
    wait_read_accept();
    wait_read_response(0, word, resp);
    check_resp("rresp of simultaneous read", resp, resp_okay_c);
    check_data("rdata of simultaneous read", word, expected_word(index));
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    for (int i = 0; i < reg_count_c; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    reset_values_read();
    full_word_writes();
    partial_strobe_writes();
    id_register_write();
    response_backpressure();
    simultaneous_write_read();

    @(posedge clock);
    if (i_dut.i_axil_to_axis.i_assertions.fail_count != 0) begin
      stop_with_failure($sformatf("%0d bound assertion checks did not hold",
                                  i_dut.i_axil_to_axis.i_assertions.fail_count));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axil_to_axis.sv ====
`default_nettype none

module axil_to_axis (
  input  wire                                         clock,
  input  wire                                         reset,

  // AXI4-Lite slave
  input  wire                                         awvalid_i,
  output logic                                        awready_o,
  input  wire  [spi_link_pkg::axil_addr_bits_c-1:0]   awaddr_i,
  input  wire                                         wvalid_i,
  output logic                                        wready_o,
  input  wire  [spi_link_pkg::axil_data_bits_c-1:0]   wdata_i,
  input  wire  [spi_link_pkg::axil_data_bits_c/8-1:0] wstrb_i,
  output logic                                        bvalid_o,
  input  wire                                         bready_i,
  output logic [1:0]                                  bresp_o,
  input  wire                                         arvalid_i,
  output logic                                        arready_o,
  input  wire  [spi_link_pkg::axil_addr_bits_c-1:0]   araddr_i,
  output logic                                        rvalid_o,
  input  wire                                         rready_i,
  output logic [spi_link_pkg::axil_data_bits_c-1:0]   rdata_o,
  output logic [1:0]                                  rresp_o,

  // Bytes returned from the link
  input  wire                                         rx_valid_i,
  input  wire  [7:0]                                  rx_data_i,

  // Request bytes towards the link
  output logic                                        tx_valid_o,
  input  wire                                         tx_ready_i,
  output logic                                        tx_last_o,
  output logic [7:0]                                  tx_data_o
);

  import spi_link_pkg::*;

  logic [2:0] state_q;
  logic [2:0] byte_idx_q;
  logic pending_q;
  frame_hdr_u hdr_q;
  logic [axil_data_bits_c/8-1:0] strb_q;
  logic [axil_data_bits_c-1:0] wdata_q;
  logic [1:0] resp_q;

  logic aw_take;
  frame_hdr_u req_hdr;
  frame_hdr_u rx_hdr;
  logic [7:0] req_byte;
  logic req_last;

  // A write needs both address and data present
  assign aw_take = awvalid_i && wvalid_i;
  assign rx_hdr = rx_data_i;

  always_comb begin
    req_hdr = '0;
    req_hdr.req.write = aw_take;
    req_hdr.req.index = aw_take ? awaddr_i[reg_index_bits_c+1:2] : araddr_i[reg_index_bits_c+1:2];
  end

  // Request frame: header, strobe, then data LSB first
  always_comb begin
    case (byte_idx_q)
      3'd0: req_byte = hdr_q;
      3'd1: req_byte = {4'h0, strb_q};
      3'd2: req_byte = wdata_q[7:0];
      3'd3: req_byte = wdata_q[15:8];
      3'd4: req_byte = wdata_q[23:16];
      default: req_byte = wdata_q[31:24];
    endcase
  end

  assign req_last = hdr_q.req.write ? (byte_idx_q == 3'd5) : 1'b1;

  // One byte in flight, the next waits for the returned byte
  assign tx_valid_o = !pending_q &&
                      (state_q == st_send_c || state_q == st_poll_c || state_q == st_recv_c);
  assign tx_data_o = (state_q == st_send_c) ? req_byte : fill_byte_c;
  // Polls are single-byte frames, the read data comes in one frame of four
  assign tx_last_o = (state_q == st_send_c) ? req_last :
                     (state_q == st_poll_c) || (byte_idx_q == 3'd3);

  assign bresp_o = resp_q;
  assign rresp_o = resp_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle_c;
      byte_idx_q <= '0;
      pending_q <= 1'b0;
      awready_o <= 1'b0;
      wready_o <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      awready_o <= 1'b0;
      wready_o <= 1'b0;
      arready_o <= 1'b0;

      if (tx_valid_o && tx_ready_i) begin
        pending_q <= 1'b1;
      end else if (rx_valid_i) begin
        pending_q <= 1'b0;
      end

      case (state_q)
        st_idle_c: begin
          byte_idx_q <= '0;
          // Writes win over reads
          if (aw_take) begin
            awready_o <= 1'b1;
            wready_o <= 1'b1;
            state_q <= st_send_c;
          end else if (arvalid_i) begin
            arready_o <= 1'b1;
            state_q <= st_send_c;
          end
        end

        st_send_c: begin
          // Advance on the returned byte so byte_idx_q names the byte in flight
          if (rx_valid_i) begin
            if (req_last) begin
              byte_idx_q <= '0;
              state_q <= st_poll_c;
            end else begin
              byte_idx_q <= byte_idx_q + 3'd1;
            end
          end
        end

        st_poll_c: begin
          if (rx_valid_i && rx_hdr.rep.marker) begin
            if (rx_hdr.rep.read) begin
              state_q <= st_recv_c;
            end else begin
              bvalid_o <= 1'b1;
              state_q <= st_resp_c;
            end
          end
        end

        st_recv_c: begin
          if (rx_valid_i) begin
            byte_idx_q <= byte_idx_q + 3'd1;
            if (byte_idx_q == 3'd3) begin
              rvalid_o <= 1'b1;
              state_q <= st_resp_c;
            end
          end
        end

        default: begin
          if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            state_q <= st_idle_c;
          end
        end
      endcase
    end
  end

  // Transaction and response payload
  always_ff @(posedge clock) begin
    if (state_q == st_idle_c) begin
      hdr_q <= req_hdr;
      strb_q <= wstrb_i;
      wdata_q <= wdata_i;
    end
    if (rx_valid_i && state_q == st_poll_c && rx_hdr.rep.marker) begin
      resp_q <= rx_hdr.rep.resp;
    end
    if (rx_valid_i && state_q == st_recv_c) begin
      rdata_o[8*byte_idx_q[1:0] +: 8] <= rx_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axis_to_regs.sv ====
`default_nettype none

module axis_to_regs (
  input  wire        clock,
  input  wire        reset,

  input  wire        rx_valid_i,
  input  wire  [7:0] rx_data_i,
  input  wire        rx_last_i,

  output logic       reply_valid_o,
  input  wire        reply_ready_i,
  output logic [7:0] reply_data_o
);

  import spi_link_pkg::*;

  logic [axil_data_bits_c-1:0] bank_q [reg_count_c];
  logic [1:0] parse_q;
  logic [1:0] byte_cnt_q;
  frame_hdr_u hdr_q;
  logic [axil_data_bits_c/8-1:0] strb_q;
  logic [23:0] data_q;
  logic [39:0] reply_buf_q;
  logic [2:0] reply_cnt_q;
  // The byte now on MISO is a reply byte
  logic reply_sending_q;

  frame_hdr_u rx_hdr;
  frame_hdr_u rsp_hdr;
  logic rx_take;
  logic rd_done;
  logic wr_done;
  logic id_hit;
  logic [axil_data_bits_c-1:0] rd_word;
  logic [axil_data_bits_c-1:0] wr_word;

  assign rx_hdr = rx_data_i;
  // An early chip-select rise drops whatever was parsed
  // Bytes clocked in while a reply is queued or going out are polls
  assign rx_take = rx_valid_i && !rx_last_i && !reply_valid_o && !reply_sending_q;
  assign rd_done = rx_take && (parse_q == parse_hdr_c) && !rx_hdr.req.write;
  assign wr_done = rx_take && (parse_q == parse_data_c) && (byte_cnt_q == 2'd3);
  assign id_hit = (hdr_q.req.index == id_reg_index_c);

  assign rd_word = (rx_hdr.req.index == id_reg_index_c) ? id_reg_value_c :
                   bank_q[rx_hdr.req.index];
  assign wr_word = {rx_data_i, data_q};

  always_comb begin
    rsp_hdr = '0;
    rsp_hdr.rep.marker = 1'b1;
    rsp_hdr.rep.read = (parse_q == parse_hdr_c);
    rsp_hdr.rep.resp = (parse_q == parse_data_c && id_hit) ? resp_slverr_c : resp_okay_c;
  end

  assign reply_valid_o = (reply_cnt_q != 3'd0);
  assign reply_data_o = reply_buf_q[7:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      parse_q <= parse_hdr_c;
      byte_cnt_q <= 2'd0;
      reply_cnt_q <= 3'd0;
      reply_sending_q <= 1'b0;
    end else begin
      if (reply_valid_o && reply_ready_i) begin
        reply_cnt_q <= reply_cnt_q - 3'd1;
      end
      if (reply_ready_i) begin
        reply_sending_q <= reply_valid_o;
      end

      if (rx_last_i) begin
        parse_q <= parse_hdr_c;
      end else if (rx_take) begin
        case (parse_q)
          parse_hdr_c: begin
            if (rx_hdr.req.write) begin
              parse_q <= parse_strb_c;
            end else begin
              // Header plus four data bytes
              reply_cnt_q <= 3'd5;
            end
          end
          parse_strb_c: begin
            byte_cnt_q <= 2'd0;
            parse_q <= parse_data_c;
          end
          default: begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) begin
              reply_cnt_q <= 3'd1;
              parse_q <= parse_hdr_c;
            end
          end
        endcase
      end
    end
  end

  // Request fields and the reply queue
  always_ff @(posedge clock) begin
    if (rx_take && parse_q == parse_hdr_c) begin
      hdr_q <= rx_hdr;
    end
    if (rx_take && parse_q == parse_strb_c) begin
      strb_q <= rx_data_i[3:0];
    end
    if (rx_take && parse_q == parse_data_c && byte_cnt_q != 2'd3) begin
      data_q[8*byte_cnt_q +: 8] <= rx_data_i;
    end

    if (rd_done) begin
      reply_buf_q <= {rd_word, rsp_hdr};
    end else if (wr_done) begin
      reply_buf_q <= {32'h0, rsp_hdr};
    end else if (reply_valid_o && reply_ready_i) begin
      reply_buf_q <= {8'h00, reply_buf_q[39:8]};
    end
  end

  // Byte-merged writes, the ID register refuses them
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count_c; i++) begin
        bank_q[i] <= '0;
      end
    end else if (wr_done && !id_hit) begin
      for (int b = 0; b < axil_data_bits_c / 8; b++) begin
        if (strb_q[b]) begin
          bank_q[hdr_q.req.index][8*b +: 8] <= wr_word[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_bridge_top.sv ====
`default_nettype none

module spi_bridge_top (
  input  wire                                         clock,
  input  wire                                         reset,

  input  wire                                         awvalid_i,
  output logic                                        awready_o,
  input  wire  [spi_link_pkg::axil_addr_bits_c-1:0]   awaddr_i,
  input  wire                                         wvalid_i,
  output logic                                        wready_o,
  input  wire  [spi_link_pkg::axil_data_bits_c-1:0]   wdata_i,
  input  wire  [spi_link_pkg::axil_data_bits_c/8-1:0] wstrb_i,
  output logic                                        bvalid_o,
  input  wire                                         bready_i,
  output logic [1:0]                                  bresp_o,
  input  wire                                         arvalid_i,
  output logic                                        arready_o,
  input  wire  [spi_link_pkg::axil_addr_bits_c-1:0]   araddr_i,
  output logic                                        rvalid_o,
  input  wire                                         rready_i,
  output logic [spi_link_pkg::axil_data_bits_c-1:0]   rdata_o,
  output logic [1:0]                                  rresp_o
);

  // Host-side byte streams
  logic tx_valid;
  logic tx_ready;
  logic tx_last;
  logic [7:0] tx_data;
  logic rx_valid;
  logic [7:0] rx_data;

  // SPI pins
  logic sclk;
  logic mosi;
  logic miso;
  logic cs_n;

  // Remote byte streams
  logic req_valid;
  logic [7:0] req_data;
  logic req_last;
  logic reply_valid;
  logic reply_ready;
  logic [7:0] reply_data;

  axil_to_axis i_axil_to_axis (
    .clock      (clock),
    .reset      (reset),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .awaddr_i   (awaddr_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .bresp_o    (bresp_o),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .araddr_i   (araddr_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .tx_valid_o (tx_valid),
    .tx_ready_i (tx_ready),
    .tx_last_o  (tx_last),
    .tx_data_o  (tx_data)
  );

  spi_byte_master i_spi_byte_master (
    .clock      (clock),
    .reset      (reset),
    .tx_valid_i (tx_valid),
    .tx_ready_o (tx_ready),
    .tx_last_i  (tx_last),
    .tx_data_i  (tx_data),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data),
    .sclk_o     (sclk),
    .mosi_o     (mosi),
    .miso_i     (miso),
    .cs_n_o     (cs_n)
  );

  spi_byte_target i_spi_byte_target (
    .clock         (clock),
    .reset         (reset),
    .sclk_i        (sclk),
    .mosi_i        (mosi),
    .cs_n_i        (cs_n),
    .miso_o        (miso),
    .rx_valid_o    (req_valid),
    .rx_data_o     (req_data),
    .rx_last_o     (req_last),
    .reply_valid_i (reply_valid),
    .reply_ready_o (reply_ready),
    .reply_data_i  (reply_data)
  );

  axis_to_regs i_axis_to_regs (
    .clock         (clock),
    .reset         (reset),
    .rx_valid_i    (req_valid),
    .rx_data_i     (req_data),
    .rx_last_i     (req_last),
    .reply_valid_o (reply_valid),
    .reply_ready_i (reply_ready),
    .reply_data_o  (reply_data)
  );

endmodule

`default_nettype wire

// ==== verilog/spi_byte_master.sv ====
`default_nettype none

module spi_byte_master (
  input  wire        clock,
  input  wire        reset,

  input  wire        tx_valid_i,
  output logic       tx_ready_o,
  input  wire        tx_last_i,
  input  wire  [7:0] tx_data_i,

  output logic       rx_valid_o,
  output logic [7:0] rx_data_o,

  output logic       sclk_o,
  output logic       mosi_o,
  input  wire        miso_i,
  output logic       cs_n_o
);

  import spi_link_pkg::*;

  logic busy_q;
  logic last_q;
  logic [1:0] gap_q;
  logic [$clog2(sclk_half_period_c)-1:0] half_cnt_q;
  logic [3:0] edge_cnt_q;
  logic [7:0] tx_shift_q;
  logic [7:0] rx_shift_q;
  logic tick;

  assign tick = busy_q && (half_cnt_q == sclk_half_period_c - 1);
  assign tx_ready_o = !busy_q && (gap_q == 2'd0);
  // MSB first, the next bit is set up on each falling edge
  assign mosi_o = tx_shift_q[7];

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= 1'b0;
      last_q <= 1'b0;
      gap_q <= 2'd0;
      half_cnt_q <= '0;
      edge_cnt_q <= 4'd0;
      sclk_o <= 1'b0;
      cs_n_o <= 1'b1;
      rx_valid_o <= 1'b0;
      rx_data_o <= 8'h00;
      tx_shift_q <= 8'h00;
      rx_shift_q <= 8'h00;
    end else begin
      rx_valid_o <= 1'b0;
      if (gap_q != 2'd0) begin
        gap_q <= gap_q - 2'd1;
      end

      if (tx_valid_i && tx_ready_o) begin
        busy_q <= 1'b1;
        cs_n_o <= 1'b0;
        last_q <= tx_last_i;
        tx_shift_q <= tx_data_i;
        half_cnt_q <= '0;
        edge_cnt_q <= 4'd0;
      end else if (busy_q) begin
        half_cnt_q <= tick ? '0 : half_cnt_q + 1'b1;
        if (tick) begin
          sclk_o <= ~sclk_o;
          edge_cnt_q <= edge_cnt_q + 4'd1;
          // MISO is taken late, at the falling edge, to cover the target's
          // oversampling delay
          if (sclk_o) begin
            rx_shift_q <= {rx_shift_q[6:0], miso_i};
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};
            if (edge_cnt_q == 4'd15) begin
              busy_q <= 1'b0;
              rx_valid_o <= 1'b1;
              rx_data_o <= {rx_shift_q[6:0], miso_i};
              if (last_q) begin
                cs_n_o <= 1'b1;
                gap_q <= 2'd2;
              end
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_byte_target.sv ====
`default_nettype none

module spi_byte_target (
  input  wire        clock,
  input  wire        reset,

  input  wire        sclk_i,
  input  wire        mosi_i,
  input  wire        cs_n_i,
  output logic       miso_o,

  output logic       rx_valid_o,
  output logic [7:0] rx_data_o,
  output logic       rx_last_o,

  input  wire        reply_valid_i,
  output logic       reply_ready_o,
  input  wire  [7:0] reply_data_i
);

  import spi_link_pkg::*;

  logic [2:0] sclk_s;
  logic [2:0] cs_s;
  logic [1:0] mosi_s;
  logic [2:0] rbit_q;
  logic [2:0] fbit_q;
  logic [7:0] in_shift_q;
  logic [7:0] out_shift_q;
  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;

  // Edges seen on the synchronized copies, MOSI delayed to match
  assign sclk_rise = sclk_s[1] && !sclk_s[2];
  assign sclk_fall = !sclk_s[1] && sclk_s[2];
  assign cs_rise = cs_s[1] && !cs_s[2];

  assign miso_o = out_shift_q[7];
  // Next reply byte is taken at the end of each byte
  assign reply_ready_o = sclk_fall && (fbit_q == 3'd7);

  always_ff @(posedge clock) begin
    if (reset) begin
      sclk_s <= 3'b000;
      cs_s <= 3'b111;
      mosi_s <= 2'b00;
      rbit_q <= 3'd0;
      fbit_q <= 3'd0;
      in_shift_q <= 8'h00;
      out_shift_q <= fill_byte_c;
      rx_valid_o <= 1'b0;
      rx_data_o <= 8'h00;
      rx_last_o <= 1'b0;
    end else begin
      sclk_s <= {sclk_s[1:0], sclk_i};
      cs_s <= {cs_s[1:0], cs_n_i};
      mosi_s <= {mosi_s[0], mosi_i};
      rx_valid_o <= 1'b0;
      rx_last_o <= cs_rise;

      if (sclk_rise) begin
        in_shift_q <= {in_shift_q[6:0], mosi_s[1]};
        rbit_q <= rbit_q + 3'd1;
        if (rbit_q == 3'd7) begin
          rx_valid_o <= 1'b1;
          rx_data_o <= {in_shift_q[6:0], mosi_s[1]};
        end
      end else if (cs_s[1]) begin
        rbit_q <= 3'd0;
      end

      if (sclk_fall) begin
        fbit_q <= fbit_q + 3'd1;
        if (fbit_q == 3'd7) begin
          out_shift_q <= reply_valid_i ? reply_data_i : fill_byte_c;
        end else begin
          out_shift_q <= {out_shift_q[6:0], 1'b0};
        end
      end else if (cs_s[1]) begin
        fbit_q <= 3'd0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_link_pkg.sv ====
`default_nettype none

package spi_link_pkg;

  // Remote register bank
  localparam int reg_count_c = 16;
  localparam int reg_index_bits_c = 4;
  localparam int id_reg_index_c = 15;
  localparam logic [31:0] id_reg_value_c = 32'h5B1D_6E01;

  // AXI4-Lite host port
  localparam int axil_addr_bits_c = 6;
  localparam int axil_data_bits_c = 32;
  localparam logic [1:0] resp_okay_c = 2'b00;
  localparam logic [1:0] resp_slverr_c = 2'b10;

  // SPI link
  localparam int sclk_half_period_c = 2;
  localparam logic [7:0] fill_byte_c = 8'h00;

  // Translator FSM states
  localparam logic [2:0] st_idle_c = 3'd0;
  localparam logic [2:0] st_send_c = 3'd1;
  localparam logic [2:0] st_poll_c = 3'd2;
  localparam logic [2:0] st_recv_c = 3'd3;
  localparam logic [2:0] st_resp_c = 3'd4;

  // Executor parser states
  localparam logic [1:0] parse_hdr_c = 2'd0;
  localparam logic [1:0] parse_strb_c = 2'd1;
  localparam logic [1:0] parse_data_c = 2'd2;

  // Header byte, read as a request or as a reply
  typedef union packed {
    struct packed {
      logic                        write;
      logic [2:0]                  rsvd;
      logic [reg_index_bits_c-1:0] index;
    } req;
    struct packed {
      logic       marker;
      logic       read;
      logic [1:0] resp;
      logic [3:0] rsvd;
    } rep;
  } frame_hdr_u;

endpackage

`default_nettype wire
